// File: files.f
+incdir+source
source/pci_bus_pkg.sv
source/pci_ctrl_pkg.sv
source/uart_link.sv
source/host_controller.sv
source/obi_wb_bridge.sv
source/shared_memory.sv
source/processorci_top.sv
dv/processorci_assertions.sv
dv/processorci_tb.sv

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module processorci_tb -f files.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Simulation finished: PASS"; then
    exit 0
fi
exit 1

// File: dv/processorci_tb.sv
`include "pci_defines.svh"

module processorci_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import pci_bus_pkg::*;
    import pci_ctrl_pkg::*;

    localparam int CLKS_PER_BIT = `CLOCK_FREQ / `BIT_RATE;
    localparam int FRAME_CLKS = 10 * CLKS_PER_BIT;
    localparam logic [31:0] LFSR_SEED = 32'h28f1;
    localparam int OBI_TIMEOUT = 50;

    // UART frames per test, commands and replies together
    localparam int FRAMES_PING = 2;
    localparam int FRAMES_MEM = 224;
    localparam int FRAMES_CREDIT = 19;
    localparam int FRAMES_RUN = 4;
    localparam int FRAMES_CORE = 33;
    localparam int FRAMES_BAD = 4;
    localparam int TOTAL_FRAMES = FRAMES_PING + FRAMES_MEM + FRAMES_CREDIT + FRAMES_RUN
                                  + FRAMES_CORE + FRAMES_BAD;
    localparam int WATCHDOG_CLKS = TOTAL_FRAMES * FRAME_CLKS + 5000;

    logic        sys_clk = 1'b0;
    logic        rst_n;
    logic        uart_rx;
    logic        uart_tx;
    obi_req_t    core_obi_req;
    obi_rsp_t    core_obi_rsp;
    logic        core_rst_n;

    logic [31:0] lfsr_q = LFSR_SEED;
    logic [31:0] ref_mem [`MEMORY_WORDS];
    logic [7:0]  rx_q [$];          // Bytes decoded from uart_tx
    int          errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    processorci_top dut0 (
        .sys_clk        (sys_clk),
        .rst_n_i        (rst_n),
        .uart_rx_i      (uart_rx),
        .uart_tx_o      (uart_tx),
        .core_obi_req_i (core_obi_req),
        .core_obi_rsp_o (core_obi_rsp),
        .core_rst_n_o   (core_rst_n)
    );

    always #10 sys_clk = ~sys_clk;

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_take(input int nbits);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < nbits; i++) begin
            fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            val = {val[30:0], fb};
        end
        return val;
    endfunction

    function automatic int word_index(input logic [31:0] addr);
        return int'((addr >> 2) % 32'(`MEMORY_WORDS));
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("mismatch at %0t: %s = %h, expected %h", $time, name, got, exp);
        errors++;
    endtask

    task automatic end_test(input string name, input int start_errors);
        tests_run++;
        if (errors == start_errors) begin
            $display("%0t: %s passed", $time, name);
        end else begin
            tests_failed++;
            $display("%0t: %s failed with %0d errors", $time, name, errors - start_errors);
        end
    endtask

    task automatic send_byte(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};   // Stop, data LSB first, start
        for (int i = 0; i < 10; i++) begin
            @(posedge sys_clk);
            uart_rx <= frame[i];
            repeat (CLKS_PER_BIT - 1) @(posedge sys_clk);
        end
    endtask

    task automatic send_word(input logic [31:0] w);
        for (int i = 0; i < 4; i++) begin
            send_byte(w[8*i +: 8]);
        end
    endtask

    // Collects nbytes from the monitor queue, LSB first
    task automatic wait_reply(input int nbytes, output logic [31:0] data);
        int waited;
        waited = 0;
        data = '0;
        while (rx_q.size() < nbytes && waited < (nbytes + 1) * FRAME_CLKS) begin
            @(negedge sys_clk);
            waited++;
        end
        if (rx_q.size() < nbytes) begin
            $display("%0t: reply timed out, expected %0d bytes and got %0d",
                     $time, nbytes, rx_q.size());
            errors++;
            rx_q.delete();
        end else begin
            for (int i = 0; i < nbytes; i++) begin
                data[8*i +: 8] = rx_q.pop_front();
            end
            if (rx_q.size() != 0) begin
                $display("%0t: reply has %0d more bytes than expected", $time, rx_q.size());
                errors++;
                rx_q.delete();
            end
        end
    endtask

    task automatic byte_cmd(input logic [7:0] cmd, input logic [7:0] exp);
        logic [31:0] rsp;
        send_byte(cmd);
        wait_reply(1, rsp);
        if (rsp[7:0] !== exp) begin
            report_mismatch($sformatf("reply to %h", cmd), 32'(rsp[7:0]), 32'(exp));
        end
    endtask

    task automatic write_cmd(input logic [31:0] addr, input logic [31:0] data);
        logic [31:0] rsp;
        send_byte(OP_WRITE);
        send_word(addr);
        send_word(data);
        wait_reply(1, rsp);
        if (rsp[7:0] !== REPLY_OK) begin
            report_mismatch("write reply", 32'(rsp[7:0]), 32'(REPLY_OK));
        end
        ref_mem[word_index(addr)] = data;
    endtask

    task automatic read_cmd(input logic [31:0] addr, output logic [31:0] data);
        send_byte(OP_READ);
        send_word(addr);
        wait_reply(4, data);
    endtask

    // Core model, one transaction with gnt and rvalid checks
    task automatic obi_access(input logic we, input logic [3:0] be, input logic [31:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        obi_req_t req;
        int       wait_cycles;
        req.req = 1'b1;
        req.we = we;
        req.be = be;
        req.addr = addr;
        req.wdata = wdata;
        wait_cycles = 0;
        rdata = 'x;
        @(posedge sys_clk);
        core_obi_req <= req;
        @(negedge sys_clk);
        while (core_obi_rsp.gnt !== 1'b1 && wait_cycles < OBI_TIMEOUT) begin
            wait_cycles++;
            @(negedge sys_clk);
        end
        @(posedge sys_clk);
        core_obi_req <= '0;
        if (wait_cycles >= OBI_TIMEOUT) begin
            $display("%0t: OBI request was never granted", $time);
            errors++;
        end else begin
            if (wait_cycles != 2) begin
                report_mismatch("gnt latency", 32'(wait_cycles), 32'd2);
            end
            @(negedge sys_clk);
            if (core_obi_rsp.rvalid !== 1'b1) begin
                $display("%0t: rvalid missing one cycle after gnt", $time);
                errors++;
            end
            rdata = core_obi_rsp.rdata;
        end
    endtask

    task automatic reset_and_ping();
        int start_errors;
        start_errors = errors;
        @(negedge sys_clk);
        if (core_rst_n !== 1'b0) begin
            report_mismatch("core_rst_n_o", 32'(core_rst_n), 32'd0);
        end
        byte_cmd(OP_PING, `BOARD_ID);
        end_test("reset_and_ping", start_errors);
    endtask

    task automatic write_read_alias();
        int          start_errors;
        logic [31:0] addrs [8];
        logic [31:0] rd;
        logic [31:0] exp;
        start_errors = errors;
        for (int n = 0; n < 8; n++) begin
            addrs[n] = lfsr_take(32);
            write_cmd(addrs[n], lfsr_take(32));
        end
        for (int n = 0; n < 8; n++) begin
            exp = ref_mem[word_index(addrs[n])];
            read_cmd(addrs[n], rd);
            if (rd !== exp) begin
                report_mismatch("read data", rd, exp);
            end
            // One memory size higher lands on the same word
            read_cmd(addrs[n] + 32'(4 * `MEMORY_WORDS), rd);
            if (rd !== exp) begin
                report_mismatch("aliased read data", rd, exp);
            end
        end
        end_test("write_read_alias", start_errors);
    endtask

    task automatic read_under_credit_stall();
        int          start_errors;
        logic [31:0] addr;
        logic [31:0] word;
        logic [31:0] rd;
        start_errors = errors;
        addr = lfsr_take(32);
        word = lfsr_take(32);
        write_cmd(addr, word);
        read_cmd(addr, rd);   // 4 bytes against 2 credits
        for (int i = 0; i < 4; i++) begin
            if (rd[8*i +: 8] !== word[8*i +: 8]) begin
                report_mismatch($sformatf("read byte %0d", i), 32'(rd[8*i +: 8]),
                                32'(word[8*i +: 8]));
            end
        end
        end_test("read_under_credit_stall", start_errors);
    endtask

    task automatic run_and_halt();
        int start_errors;
        start_errors = errors;
        byte_cmd(OP_RUN, REPLY_OK);
        if (core_rst_n !== 1'b1) begin
            report_mismatch("core_rst_n_o", 32'(core_rst_n), 32'd1);
        end
        byte_cmd(OP_HALT, REPLY_OK);
        if (core_rst_n !== 1'b0) begin
            report_mismatch("core_rst_n_o", 32'(core_rst_n), 32'd0);
        end
        end_test("run_and_halt", start_errors);
    endtask

    task automatic core_port_merge();
        int          start_errors;
        int          idx;
        logic [31:0] addr;
        logic [31:0] new_word;
        logic [3:0]  be;
        logic [31:0] rd;
        start_errors = errors;
        byte_cmd(OP_RUN, REPLY_OK);
        addr = lfsr_take(32);
        idx = word_index(addr);
        write_cmd(addr, lfsr_take(32));
        new_word = lfsr_take(32);
        be = 4'(lfsr_take(4));
        if (be == 4'h0) begin
            be = 4'h1;
        end
        obi_access(1'b1, be, addr, new_word, rd);
        if (rd !== 32'h0) begin
            report_mismatch("rdata after write", rd, 32'h0);
        end
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                ref_mem[idx][8*b +: 8] = new_word[8*b +: 8];
            end
        end
        read_cmd(addr, rd);
        if (rd !== ref_mem[idx]) begin
            report_mismatch("merged word", rd, ref_mem[idx]);
        end
        // Next word written by the host, read back by the core
        write_cmd(addr + 32'd4, lfsr_take(32));
        obi_access(1'b0, 4'hF, addr + 32'd4, 32'h0, rd);
        if (rd !== ref_mem[word_index(addr + 32'd4)]) begin
            report_mismatch("rdata", rd, ref_mem[word_index(addr + 32'd4)]);
        end
        byte_cmd(OP_HALT, REPLY_OK);
        end_test("core_port_merge", start_errors);
    endtask

    task automatic unknown_opcode();
        int start_errors;
        start_errors = errors;
        byte_cmd(8'h3F, REPLY_ERR);
        byte_cmd(OP_PING, `BOARD_ID);
        end_test("unknown_opcode", start_errors);
    endtask

    // UART receiver for the DUT's replies, samples at mid bit
    initial begin : uart_monitor
        logic [7:0] rx_bits;
        forever begin
            @(negedge sys_clk);
            if (rst_n && uart_tx === 1'b0) begin
                repeat (CLKS_PER_BIT / 2 - 1) @(negedge sys_clk);
                for (int i = 0; i < 8; i++) begin
                    repeat (CLKS_PER_BIT) @(negedge sys_clk);
                    rx_bits[i] = uart_tx;
                end
                repeat (CLKS_PER_BIT) @(negedge sys_clk);
                if (uart_tx !== 1'b1) begin
                    $display("%0t: framing error, stop bit on uart_tx is low", $time);
                    errors++;
                end
                rx_q.push_back(rx_bits);
            end
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CLKS) @(posedge sys_clk);
        $display("%0t: watchdog expired after %0d clocks, run stopped", $time, WATCHDOG_CLKS);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        rst_n = 1'b0;
        uart_rx = 1'b1;             // Idle line
        core_obi_req = '0;
        repeat (4) @(posedge sys_clk);
        rst_n <= 1'b1;
        @(posedge sys_clk);

        reset_and_ping();
        write_read_alias();
        read_under_credit_stall();
        run_and_halt();
        core_port_merge();
        unknown_opcode();

        repeat (2 * FRAME_CLKS) @(posedge sys_clk);
        if (rx_q.size() != 0) begin
            $display("%0t: %0d stray bytes arrived after the last reply", $time, rx_q.size());
            errors++;
        end
        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: dv/processorci_assertions.sv
`include "pci_defines.svh"

module processorci_assertions #(
    parameter int CRED_W = $clog2(`TX_CREDITS + 1)
) (
    input logic              sys_clk,
    input logic              rst_n_i,
    input logic [CRED_W-1:0] tx_credits_i,
    input logic              tx_valid_i,
    input logic              tx_credit_i,
    input logic              core_rst_n_i,
    input logic              ack_i,
    input logic              stb_i
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [CRED_W-1:0] in_flight_q;   // Bytes in the FIFO or on the line

    always_ff @(posedge sys_clk) begin
        if (!rst_n_i) begin
            in_flight_q <= '0;
        end else begin
            case ({tx_valid_i, tx_credit_i})
                2'b10:   in_flight_q <= in_flight_q + 1'b1;
                2'b01:   in_flight_q <= in_flight_q - 1'b1;
                default: in_flight_q <= in_flight_q;
            endcase
        end
    end

    // FIFO depth bounds the credit count
    credit_bound: assert property (@(posedge sys_clk) disable iff (!rst_n_i)
        tx_credits_i <= CRED_W'(`TX_CREDITS))
        else $error("credit count above TX FIFO depth");

    // Counted from sends and returned credits
    send_needs_credit: assert property (@(posedge sys_clk) disable iff (!rst_n_i)
        tx_valid_i |-> in_flight_q < CRED_W'(`TX_CREDITS))
        else $error("tx_valid raised with no credits left");

    ack_needs_stb: assert property (@(posedge sys_clk) disable iff (!rst_n_i)
        ack_i |-> stb_i)
        else $error("Wishbone ack without stb");

    // Core stays in reset right after a system reset
    core_held_in_reset: assert property (@(posedge sys_clk)
        !rst_n_i |=> !core_rst_n_i)
        else $error("core_rst_n high in the cycle after reset");

endmodule

bind host_controller processorci_assertions u_ctrl_checks (
    .sys_clk      (sys_clk),
    .rst_n_i      (rst_n_i),
    .tx_credits_i (tx_credits_q),
    .tx_valid_i   (tx_valid_o),
    .tx_credit_i  (tx_credit_i),
    .core_rst_n_i (core_rst_n_o),
    .ack_i        (wb_rsp_i.ack),
    .stb_i        (wb_req_o.stb)
);

// Only the core side of the arbiter is watched here
bind shared_memory processorci_assertions u_mem_checks (
    .sys_clk      (sys_clk),
    .rst_n_i      (rst_n_i),
    .tx_credits_i ('0),
    .tx_valid_i   (1'b0),
    .tx_credit_i  (1'b0),
    .core_rst_n_i (1'b0),
    .ack_i        (core_rsp_o.ack),
    .stb_i        (core_req_i.stb)
);

// File: source/processorci_top.sv
module processorci_top (
    input  logic                  sys_clk,
    input  logic                  rst_n_i,
    input  logic                  uart_rx_i,
    output logic                  uart_tx_o,
    input  pci_bus_pkg::obi_req_t core_obi_req_i,
    output pci_bus_pkg::obi_rsp_t core_obi_rsp_o,
    output logic                  core_rst_n_o
);
    import pci_bus_pkg::*;

    // UART byte path
    logic [7:0] rx_byte;
    logic       rx_valid;
    logic [7:0] tx_byte;
    logic       tx_valid;
    logic       tx_credit;

    wb_req_t    host_wb_req;
    wb_rsp_t    host_wb_rsp;
    wb_req_t    core_wb_req;   // Bridged core data port
    wb_rsp_t    core_wb_rsp;

    uart_link u_link (
        .sys_clk     (sys_clk),
        .rst_n_i     (rst_n_i),
        .uart_rx_i   (uart_rx_i),
        .uart_tx_o   (uart_tx_o),
        .rx_byte_o   (rx_byte),
        .rx_valid_o  (rx_valid),
        .tx_byte_i   (tx_byte),
        .tx_valid_i  (tx_valid),
        .tx_credit_o (tx_credit)
    );

    host_controller u_ctrl (
        .sys_clk      (sys_clk),
        .rst_n_i      (rst_n_i),
        .rx_byte_i    (rx_byte),
        .rx_valid_i   (rx_valid),
        .tx_byte_o    (tx_byte),
        .tx_valid_o   (tx_valid),
        .tx_credit_i  (tx_credit),
        .wb_req_o     (host_wb_req),
        .wb_rsp_i     (host_wb_rsp),
        .core_rst_n_o (core_rst_n_o)
    );

    obi_wb_bridge u_bridge (
        .sys_clk   (sys_clk),
        .rst_n_i   (rst_n_i),
        .obi_req_i (core_obi_req_i),
        .obi_rsp_o (core_obi_rsp_o),
        .wb_req_o  (core_wb_req),
        .wb_rsp_i  (core_wb_rsp)
    );

    shared_memory u_mem (
        .sys_clk    (sys_clk),
        .rst_n_i    (rst_n_i),
        .host_req_i (host_wb_req),
        .core_req_i (core_wb_req),
        .host_rsp_o (host_wb_rsp),
        .core_rsp_o (core_wb_rsp)
    );

endmodule

// File: source/shared_memory.sv
`include "pci_defines.svh"

module shared_memory (
    input  logic                 sys_clk,
    input  logic                 rst_n_i,
    input  pci_bus_pkg::wb_req_t host_req_i,
    input  pci_bus_pkg::wb_req_t core_req_i,
    output pci_bus_pkg::wb_rsp_t host_rsp_o,
    output pci_bus_pkg::wb_rsp_t core_rsp_o
);
    import pci_bus_pkg::*;

    localparam int IDX_W = $clog2(`MEMORY_WORDS);

    logic [31:0]      ram [`MEMORY_WORDS];
    logic             gnt_host_q;
    logic             gnt_core_q;
    logic             ack_q;
    logic [31:0]      rdata_q;
    wb_req_t          sel_req;
    logic [IDX_W-1:0] word_idx;
    logic             access;

    assign sel_req  = gnt_host_q ? host_req_i : core_req_i;
    assign word_idx = sel_req.adr[IDX_W+1:2];   // Upper address bits wrap
    assign access   = (gnt_host_q || gnt_core_q) && sel_req.cyc && sel_req.stb && !ack_q;

    // Grant only from idle, host first; held through the ack cycle
    always_ff @(posedge sys_clk) begin
        if (!rst_n_i) begin
            gnt_host_q <= 1'b0;
            gnt_core_q <= 1'b0;
            ack_q      <= 1'b0;
        end else if (ack_q) begin
            gnt_host_q <= 1'b0;
            gnt_core_q <= 1'b0;
            ack_q      <= 1'b0;
        end else if (access) begin
            ack_q <= 1'b1;
        end else if (!gnt_host_q && !gnt_core_q) begin
            gnt_host_q <= host_req_i.cyc && host_req_i.stb;
            gnt_core_q <= !(host_req_i.cyc && host_req_i.stb) && core_req_i.cyc && core_req_i.stb;
        end else begin
            // Granted master dropped its strobe
            gnt_host_q <= 1'b0;
            gnt_core_q <= 1'b0;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (access) begin
            if (sel_req.we) begin
                for (int b = 0; b < 4; b++) begin
                    if (sel_req.sel[b]) begin
                        ram[word_idx][8*b +: 8] <= sel_req.dat[8*b +: 8];
                    end
                end
            end else begin
                rdata_q <= ram[word_idx];
            end
        end
    end

    assign host_rsp_o.ack = ack_q && gnt_host_q;
    assign host_rsp_o.dat = rdata_q;
    assign core_rsp_o.ack = ack_q && gnt_core_q;
    assign core_rsp_o.dat = rdata_q;

endmodule

// File: source/obi_wb_bridge.sv
module obi_wb_bridge (
    input  logic                  sys_clk,
    input  logic                  rst_n_i,
    input  pci_bus_pkg::obi_req_t obi_req_i,
    output pci_bus_pkg::obi_rsp_t obi_rsp_o,
    output pci_bus_pkg::wb_req_t  wb_req_o,
    input  pci_bus_pkg::wb_rsp_t  wb_rsp_i
);
    import pci_bus_pkg::*;

    obi_req_t    held_q;     // Request as seen in its first cycle
    obi_req_t    cur_req;
    logic        busy_q;     // Wishbone cycle open, waiting for ack
    logic        rvalid_q;
    logic [31:0] rdata_q;
    logic        stb;

    // A new request waits out the rvalid cycle of the previous one
    assign stb     = !rvalid_q && (busy_q || obi_req_i.req);
    assign cur_req = busy_q ? held_q : obi_req_i;

    assign wb_req_o.cyc = stb;
    assign wb_req_o.stb = stb;
    assign wb_req_o.we  = cur_req.we;
    assign wb_req_o.sel = cur_req.be;
    assign wb_req_o.adr = cur_req.addr;
    assign wb_req_o.dat = cur_req.wdata;

    assign obi_rsp_o.gnt    = wb_rsp_i.ack;   // Grant in the ack cycle
    assign obi_rsp_o.rvalid = rvalid_q;
    assign obi_rsp_o.rdata  = rdata_q;

    always_ff @(posedge sys_clk) begin
        if (!rst_n_i) begin
            busy_q   <= 1'b0;
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= wb_rsp_i.ack;
            if (wb_rsp_i.ack) begin
                busy_q <= 1'b0;
            end else if (stb) begin
                busy_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        if (stb && !busy_q) begin
            held_q <= obi_req_i;
        end
        if (wb_rsp_i.ack) begin
            rdata_q <= cur_req.we ? 32'h0 : wb_rsp_i.dat;
        end
    end

endmodule

// File: source/host_controller.sv
`include "pci_defines.svh"

module host_controller (
    input  logic                 sys_clk,
    input  logic                 rst_n_i,
    input  logic [7:0]           rx_byte_i,
    input  logic                 rx_valid_i,
    output logic [7:0]           tx_byte_o,
    output logic                 tx_valid_o,
    input  logic                 tx_credit_i,
    output pci_bus_pkg::wb_req_t wb_req_o,
    input  pci_bus_pkg::wb_rsp_t wb_rsp_i,
    output logic                 core_rst_n_o
);
    import pci_ctrl_pkg::*;

    localparam int CRED_W = $clog2(`TX_CREDITS + 1);

    ctrl_state_e       state_q;
    host_op_e          op_q;
    logic [1:0]        byte_cnt_q;
    logic [31:0]       addr_q;
    logic [31:0]       data_q;
    logic [31:0]       reply_q;        // Sent LSB first
    logic [2:0]        reply_left_q;
    logic [CRED_W-1:0] tx_credits_q;
    logic              core_rst_q;
    logic              send;

    // Answer to a single byte command
    function automatic logic [7:0] first_reply(input logic [7:0] cmd);
        logic [7:0] rsp;
        case (host_op_e'(cmd))
            OP_PING:                            rsp = `BOARD_ID;
            OP_WRITE, OP_READ, OP_RUN, OP_HALT: rsp = REPLY_OK;
            default:                            rsp = REPLY_ERR;
        endcase
        return rsp;
    endfunction

    assign send       = (state_q == REPLY) && (tx_credits_q != '0);
    assign tx_valid_o = send;
    assign tx_byte_o  = reply_q[7:0];

    // One access per command, full word strobes
    assign wb_req_o.cyc = (state_q == BUS);
    assign wb_req_o.stb = (state_q == BUS);
    assign wb_req_o.we  = (op_q == OP_WRITE);
    assign wb_req_o.sel = 4'hF;
    assign wb_req_o.adr = addr_q;
    assign wb_req_o.dat = data_q;

    assign core_rst_n_o = core_rst_q;

    always_ff @(posedge sys_clk) begin
        if (!rst_n_i) begin
            state_q      <= IDLE;
            op_q         <= OP_PING;
            byte_cnt_q   <= '0;
            reply_left_q <= '0;
            core_rst_q   <= 1'b0;   // Core held in reset until RUN
        end else begin
            case (state_q)
                IDLE: begin
                    if (rx_valid_i) begin
                        op_q         <= host_op_e'(rx_byte_i);
                        byte_cnt_q   <= '0;
                        reply_left_q <= 3'd1;
                        case (host_op_e'(rx_byte_i))
                            OP_WRITE, OP_READ: state_q <= GET_ADDR;
                            OP_RUN: begin
                                core_rst_q <= 1'b1;
                                state_q    <= REPLY;
                            end
                            OP_HALT: begin
                                core_rst_q <= 1'b0;
                                state_q    <= REPLY;
                            end
                            default: state_q <= REPLY;   // PING or unknown byte
                        endcase
                    end
                end
                GET_ADDR: begin
                    if (rx_valid_i) begin
                        byte_cnt_q <= byte_cnt_q + 1'b1;
                        if (byte_cnt_q == 2'd3) begin
                            state_q <= (op_q == OP_WRITE) ? GET_DATA : BUS;
                        end
                    end
                end
                GET_DATA: begin
                    if (rx_valid_i) begin
                        byte_cnt_q <= byte_cnt_q + 1'b1;
                        if (byte_cnt_q == 2'd3) begin
                            state_q <= BUS;
                        end
                    end
                end
                BUS: begin
                    if (wb_rsp_i.ack) begin
                        reply_left_q <= (op_q == OP_WRITE) ? 3'd1 : 3'd4;
                        state_q      <= REPLY;
                    end
                end
                REPLY: begin
                    // Stalls here while the FIFO is out of credits
                    if (send) begin
                        reply_left_q <= reply_left_q - 1'b1;
                        if (reply_left_q == 3'd1) begin
                            state_q <= IDLE;
                        end
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge sys_clk) begin
        if (rx_valid_i && state_q == GET_ADDR) begin
            addr_q <= {rx_byte_i, addr_q[31:8]};
        end
        if (rx_valid_i && state_q == GET_DATA) begin
            data_q <= {rx_byte_i, data_q[31:8]};
        end
        if (rx_valid_i && state_q == IDLE) begin
            reply_q <= {24'h0, first_reply(rx_byte_i)};
        end else if (state_q == BUS && wb_rsp_i.ack) begin
            reply_q <= (op_q == OP_WRITE) ? {24'h0, REPLY_OK} : wb_rsp_i.dat;
        end else if (send) begin
            reply_q <= {8'h00, reply_q[31:8]};
        end
    end

    // One credit per FIFO slot
    always_ff @(posedge sys_clk) begin
        if (!rst_n_i) begin
            tx_credits_q <= CRED_W'(`TX_CREDITS);
        end else begin
            case ({send, tx_credit_i})
                2'b10:   tx_credits_q <= tx_credits_q - 1'b1;
                2'b01:   tx_credits_q <= tx_credits_q + 1'b1;
                default: tx_credits_q <= tx_credits_q;
            endcase
        end
    end

endmodule

// File: source/uart_link.sv
`include "pci_defines.svh"

module uart_link (
    input  logic       sys_clk,
    input  logic       rst_n_i,
    input  logic       uart_rx_i,
    output logic       uart_tx_o,
    output logic [7:0] rx_byte_o,
    output logic       rx_valid_o,
    input  logic [7:0] tx_byte_i,
    input  logic       tx_valid_i,
    output logic       tx_credit_o
);
    localparam int CLKS_PER_BIT = `CLOCK_FREQ / `BIT_RATE;
    localparam int CNT_W = $clog2(CLKS_PER_BIT);
    localparam int DEPTH = `TX_CREDITS;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int LVL_W = $clog2(DEPTH + 1);
    localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(CLKS_PER_BIT - 1);
    localparam logic [CNT_W-1:0] MID_CNT = CNT_W'(CLKS_PER_BIT / 2 - 1);

    logic             rx_meta;
    logic             rx_sync;
    logic             rx_active;
    logic [CNT_W-1:0] rx_cnt;
    logic [3:0]       rx_bit;     // 0 start, 1..8 data, 9 stop

    logic [7:0]       fifo_mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [LVL_W-1:0] fifo_lvl;
    logic             pop;

    logic             tx_active;
    logic [CNT_W-1:0] tx_cnt;
    logic [3:0]       tx_bit;
    logic [9:0]       tx_shift;   // Stop, data, start

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // Line is idle high, so the synchronizer resets to 1
    always_ff @(posedge sys_clk) begin
        if (!rst_n_i) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= uart_rx_i;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (!rst_n_i) begin
            rx_active  <= 1'b0;
            rx_cnt     <= '0;
            rx_bit     <= '0;
            rx_valid_o <= 1'b0;
        end else begin
            rx_valid_o <= 1'b0;
            if (!rx_active) begin
                rx_cnt    <= '0;
                rx_bit    <= '0;
                rx_active <= !rx_sync;   // Falling edge opens a frame
            end else begin
                rx_cnt <= (rx_cnt == LAST_CNT) ? '0 : rx_cnt + 1'b1;
                if (rx_cnt == LAST_CNT) begin
                    rx_bit <= rx_bit + 1'b1;
                end
                if (rx_cnt == MID_CNT) begin
                    if (rx_bit == 4'd0 && rx_sync) begin
                        rx_active <= 1'b0;           // Glitch, not a start bit
                    end else if (rx_bit == 4'd9) begin
                        rx_active  <= 1'b0;
                        rx_valid_o <= rx_sync;       // Bad stop bit drops the byte
                    end
                end
            end
        end
    end

    // Data bits arrive LSB first
    always_ff @(posedge sys_clk) begin
        if (rx_active && rx_cnt == MID_CNT && rx_bit >= 4'd1 && rx_bit <= 4'd8) begin
            rx_byte_o <= {rx_sync, rx_byte_o[7:1]};
        end
    end

    assign pop = !tx_active && (fifo_lvl != '0);

    always_ff @(posedge sys_clk) begin
        if (tx_valid_i) begin
            fifo_mem[wr_ptr] <= tx_byte_i;
        end
    end

    // No full check, the sender holds at most DEPTH credits
    always_ff @(posedge sys_clk) begin
        if (!rst_n_i) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            fifo_lvl <= '0;
        end else begin
            if (tx_valid_i) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({tx_valid_i, pop})
                2'b10:   fifo_lvl <= fifo_lvl + 1'b1;
                2'b01:   fifo_lvl <= fifo_lvl - 1'b1;
                default: fifo_lvl <= fifo_lvl;
            endcase
        end
    end

    always_ff @(posedge sys_clk) begin
        if (!rst_n_i) begin
            tx_active   <= 1'b0;
            tx_cnt      <= '0;
            tx_bit      <= '0;
            tx_shift    <= '1;
            tx_credit_o <= 1'b0;
        end else begin
            tx_credit_o <= 1'b0;
            if (pop) begin
                tx_active <= 1'b1;
                tx_cnt    <= '0;
                tx_bit    <= '0;
                tx_shift  <= {1'b1, fifo_mem[rd_ptr], 1'b0};
            end else if (tx_active) begin
                tx_cnt <= (tx_cnt == LAST_CNT) ? '0 : tx_cnt + 1'b1;
                if (tx_cnt == LAST_CNT) begin
                    tx_shift <= {1'b1, tx_shift[9:1]};   // Ones refill the idle level
                    tx_bit   <= tx_bit + 1'b1;
                    if (tx_bit == 4'd9) begin
                        // Stop bit done, the FIFO slot is free again
                        tx_active   <= 1'b0;
                        tx_credit_o <= 1'b1;
                    end
                end
            end
        end
    end

    assign uart_tx_o = tx_shift[0];

endmodule

// File: source/pci_ctrl_pkg.sv
package pci_ctrl_pkg;

    // Host command bytes, plain ASCII
    typedef enum logic [7:0] {
        OP_PING  = 8'h50,   // 'P'
        OP_WRITE = 8'h57,   // 'W'
        OP_READ  = 8'h52,   // 'R'
        OP_RUN   = 8'h47,   // 'G'
        OP_HALT  = 8'h48    // 'H'
    } host_op_e;

    typedef enum logic [2:0] {
        IDLE,
        GET_ADDR,
        GET_DATA,
        BUS,
        REPLY
    } ctrl_state_e;

    // Single byte answers
    localparam logic [7:0] REPLY_OK  = 8'h4B;   // 'K'
    localparam logic [7:0] REPLY_ERR = 8'h45;   // 'E'

endpackage

// File: source/pci_bus_pkg.sv
package pci_bus_pkg;

    // Wishbone master to slave
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [3:0]  sel;   // Byte strobes
        logic [31:0] adr;   // Byte address
        logic [31:0] dat;
    } wb_req_t;

    // Wishbone slave to master
    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    // Core data port, request side
    typedef struct packed {
        logic        req;
        logic        we;
        logic [3:0]  be;
        logic [31:0] addr;
        logic [31:0] wdata;
    } obi_req_t;

    typedef struct packed {
        logic        gnt;
        logic        rvalid;
        logic [31:0] rdata;   // Zero on writes
    } obi_rsp_t;

endpackage

// File: source/pci_defines.svh
`ifndef PCI_DEFINES_SVH
`define PCI_DEFINES_SVH

// System clock in Hz
`define CLOCK_FREQ 50_000_000

// UART bit rate, 16 clocks per bit at CLOCK_FREQ
`define BIT_RATE 3_125_000

// Shared RAM depth in 32-bit words
`define MEMORY_WORDS 256

// Depth of the UART transmit FIFO, also the credits the controller starts with
`define TX_CREDITS 2

// Answer to a PING
`define BOARD_ID 8'h5A

`endif
